// ==== compile.f ====
+incdir+source
source/ob_pkg.sv
source/order_capture.sv
source/book_storage.sv
source/best_price_scan.sv
source/book_controller.sv
source/quote_output.sv
source/order_book_top.sv
verification/tb_clock.sv
verification/order_book_sva.sv
verification/order_book_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the order book testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module order_book_tb -f compile.f -o order_book_sim

if ./obj_dir/order_book_sim > sim.log 2>&1; then
    sim_status=0
else
    sim_status=1
fi
cat sim.log

if grep -q "Checks failed" sim.log || [ "$sim_status" -ne 0 ]; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"

// ==== verification/order_book_tb.sv ====
/* order book testbench with directed requests checked against a per-stock book model */

`timescale 1ns/1ns

`include "ob_defines.svh"

module order_book_tb
    import ob_pkg::*;
();

    localparam int WAIT_LIMIT = 5 * `OB_BOOK_DEPTH + 8;

    logic                   i_clk;
    logic                   i_reset_n;
    logic                   i_data_valid;
    logic                   i_trade_type;
    logic [`OB_STOCK_W-1:0] i_stock_id;
    logic [1:0]             i_order_type;
    logic [`OB_QTY_W-1:0]   i_quantity;
    logic [`OB_PRICE_W-1:0] i_price;
    logic [`OB_ID_W-1:0]    i_order_id;
    logic                   i_trading_logic_ready;
    logic [`OB_PRICE_W-1:0] o_best_bid;
    logic [`OB_PRICE_W-1:0] o_best_ask;
    logic                   o_matched;
    logic                   o_data_valid;
    logic                   o_book_busy;

    // reference book with side index 1 for bid and 0 for ask
    logic [`OB_PRICE_W-1:0] ref_price [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];
    logic [`OB_QTY_W-1:0]   ref_qty   [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];
    logic [`OB_ID_W-1:0]    ref_id    [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];
    int                     ref_count [`OB_NUM_STOCKS][2];

    int                     next_id;
    logic [`OB_PRICE_W-1:0] last_bid;   // sampled with the last result
    logic [`OB_PRICE_W-1:0] last_ask;

    tb_clock u_clock (.o_clk(i_clk));

    order_book_top i_dut (.*);

    bind order_book_top order_book_sva u_sva (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_ready(i_trading_logic_ready),
        .i_best_bid(o_best_bid), .i_best_ask(o_best_ask), .i_matched(o_matched),
        .i_out_valid(o_data_valid), .i_busy(o_book_busy)
    );

    function automatic int best_slot(input int stock, input int side);
        int pick;
        pick = -1;
        for (int k = 0; k < ref_count[stock][side]; k++) begin
            if (pick < 0) begin
                pick = k;
            end else if (side == 1
                         && ref_price[stock][side][k] > ref_price[stock][side][pick]) begin
                pick = k;
            end else if (side == 0
                         && ref_price[stock][side][k] < ref_price[stock][side][pick]) begin
                pick = k;
            end
        end
        return pick;
    endfunction

    function automatic logic [`OB_PRICE_W-1:0] best_price(input int stock, input int side);
        int slot;
        slot = best_slot(stock, side);
        return (slot < 0) ? '0 : ref_price[stock][side][slot];   // empty side quotes 0
    endfunction

    function automatic logic add_to_model(input int side, input int stock,
                                          input logic [`OB_QTY_W-1:0] qty,
                                          input logic [`OB_PRICE_W-1:0] price,
                                          input logic [`OB_ID_W-1:0] id);
        int n;
        n = ref_count[stock][side];
        if (n == `OB_BOOK_DEPTH) return 1'b0;   // full side drops the add
        ref_price[stock][side][n] = price;
        ref_qty[stock][side][n] = qty;
        ref_id[stock][side][n] = id;
        ref_count[stock][side] = n + 1;
        return 1'b1;
    endfunction

    function automatic void remove_slot(input int stock, input int side, input int slot);
        for (int k = slot; k < ref_count[stock][side] - 1; k++) begin
            ref_price[stock][side][k] = ref_price[stock][side][k + 1];
            ref_qty[stock][side][k] = ref_qty[stock][side][k + 1];
            ref_id[stock][side][k] = ref_id[stock][side][k + 1];
        end
        ref_count[stock][side] = ref_count[stock][side] - 1;
    endfunction

    // bid side is searched before the ask side
    function automatic logic find_order(input int stock, input logic [`OB_ID_W-1:0] id,
                                        output int side, output int slot);
        side = 0;
        slot = 0;
        for (int s = 1; s >= 0; s--) begin
            for (int k = 0; k < ref_count[stock][s]; k++) begin
                if (ref_id[stock][s][k] == id) begin
                    side = s;
                    slot = k;
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic logic cancel_in_model(input int stock, input logic [`OB_ID_W-1:0] id);
        int side;
        int slot;
        if (!find_order(stock, id, side, slot)) return 1'b0;
        remove_slot(stock, side, slot);
        return 1'b1;
    endfunction

    function automatic logic execute_in_model(input int stock, input logic [`OB_ID_W-1:0] id,
                                              input logic [`OB_QTY_W-1:0] qty);
        int side;
        int slot;
        if (!find_order(stock, id, side, slot)) return 1'b0;
        if (qty >= ref_qty[stock][side][slot]) begin
            remove_slot(stock, side, slot);
        end else begin
            ref_qty[stock][side][slot] = ref_qty[stock][side][slot] - qty;
        end
        return 1'b1;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic send_request(input order_op_e op, input logic side, input int stock,
                                input logic [`OB_QTY_W-1:0] qty,
                                input logic [`OB_PRICE_W-1:0] price,
                                input logic [`OB_ID_W-1:0] id);
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (o_book_busy || o_data_valid) begin
            if (waited == WAIT_LIMIT) report_failure("timeout waiting for the book to go idle");
            waited++;
            @(negedge i_clk);
        end
        @(posedge i_clk);
        i_data_valid <= 1'b1;
        i_trade_type <= side;
        i_stock_id   <= stock[`OB_STOCK_W-1:0];
        i_order_type <= op;
        i_quantity   <= qty;
        i_price      <= price;
        i_order_id   <= id;
        @(posedge i_clk);   // taken on this edge
        i_data_valid <= 1'b0;
    endtask

    task automatic wait_result(input int stock, input logic exp_matched, input int hold);
        int waited;
        logic [`OB_PRICE_W-1:0] exp_bid;
        logic [`OB_PRICE_W-1:0] exp_ask;
        exp_bid = best_price(stock, 1);
        exp_ask = best_price(stock, 0);
        waited = 0;
        @(negedge i_clk);
        while (!o_data_valid) begin
            if (waited == WAIT_LIMIT) report_failure("timeout waiting for o_data_valid");
            check_value("o_book_busy", o_book_busy, 1'b1);   // busy until the result is out
            waited++;
            @(negedge i_clk);
        end
        check_value("o_matched", o_matched, exp_matched);
        check_value("o_best_bid", o_best_bid, exp_bid);
        check_value("o_best_ask", o_best_ask, exp_ask);
        check_value("o_book_busy", o_book_busy, 1'b0);
        last_bid = o_best_bid;
        last_ask = o_best_ask;
        for (int c = 0; c < hold; c++) begin
            @(negedge i_clk);   // ready still low
            check_value("o_data_valid", o_data_valid, 1'b1);
            check_value("o_book_busy", o_book_busy, 1'b0);
            check_value("o_matched", o_matched, exp_matched);
            check_value("o_best_bid", o_best_bid, exp_bid);
            check_value("o_best_ask", o_best_ask, exp_ask);
        end
        @(posedge i_clk);
        i_trading_logic_ready <= 1'b1;
        @(posedge i_clk);
        i_trading_logic_ready <= 1'b0;
        @(negedge i_clk);
        check_value("o_data_valid", o_data_valid, 1'b0);
    endtask

    task automatic run_request(input order_op_e op, input logic side, input int stock,
                               input logic [`OB_QTY_W-1:0] qty,
                               input logic [`OB_PRICE_W-1:0] price,
                               input logic [`OB_ID_W-1:0] id, input int hold);
        logic exp_matched;
        case (op)
            OP_ADD:    exp_matched = add_to_model(int'(side), stock, qty, price, id);
            OP_CANCEL: exp_matched = cancel_in_model(stock, id);
            default:   exp_matched = execute_in_model(stock, id, qty);
        endcase
        send_request(op, side, stock, qty, price, id);
        wait_result(stock, exp_matched, hold);
    endtask

    task automatic check_reset_state();
        @(negedge i_clk);
        check_value("o_data_valid", o_data_valid, 1'b0);
        check_value("o_book_busy", o_book_busy, 1'b0);
        check_value("o_matched", o_matched, 1'b0);
        check_value("o_best_bid", o_best_bid, '0);
        check_value("o_best_ask", o_best_ask, '0);
    endtask

    task automatic random_adds();
        int stock;
        logic side;
        logic [`OB_PRICE_W-1:0] price;
        logic [`OB_QTY_W-1:0] qty;
        for (int i = 0; i < 18; i++) begin
            stock = i % 3;
            side  = ((i / 3) % 2) == 1;
            // bids stay below asks so the book never crosses
            price = side ? 32'(1000 + ($urandom % 500)) : 32'(2000 + ($urandom % 500));
            qty   = 16'(10 + ($urandom % 90));
            run_request(OP_ADD, side, stock, qty, price, next_id, 0);
            next_id++;
        end
    endtask

    task automatic cancel_orders();
        int slot;
        logic [`OB_PRICE_W-1:0] exp_bid;
        logic [`OB_PRICE_W-1:0] exp_ask;
        slot = best_slot(0, 1);
        run_request(OP_CANCEL, 1'b1, 0, '0, '0, ref_id[0][1][slot], 0);
        slot = best_slot(0, 0);
        run_request(OP_CANCEL, 1'b0, 0, '0, '0, ref_id[0][0][slot], 0);
        exp_bid = best_price(0, 1);
        exp_ask = best_price(0, 0);
        run_request(OP_CANCEL, 1'b1, 0, '0, '0, 32'hdead_0001, 0);   // never added
        check_value("o_best_bid", last_bid, exp_bid);
        check_value("o_best_ask", last_ask, exp_ask);
    endtask

    task automatic execute_orders();
        int slot;
        logic [`OB_ID_W-1:0] id;
        logic [`OB_PRICE_W-1:0] price;
        logic [`OB_QTY_W-1:0] qty;
        slot  = best_slot(1, 1);
        id    = ref_id[1][1][slot];
        price = ref_price[1][1][slot];
        qty   = ref_qty[1][1][slot];
        run_request(OP_EXECUTE, 1'b1, 1, qty / 2, '0, id, 0);
        check_value("o_best_bid", last_bid, price);   // partial fill keeps the order
        run_request(OP_EXECUTE, 1'b1, 1, qty - qty / 2, '0, id, 0);
        // oversized fill on the ask side
        slot = best_slot(1, 0);
        run_request(OP_EXECUTE, 1'b0, 1, 16'hffff, '0, ref_id[1][0][slot], 0);
    endtask

    task automatic fill_side();
        logic [`OB_PRICE_W-1:0] price;
        logic [`OB_PRICE_W-1:0] lowest;
        lowest = '0;
        for (int i = 0; i < `OB_BOOK_DEPTH; i++) begin
            price = 32'(3000 + 10 * i + ($urandom % 5));   // rising prices
            if (i == 0) lowest = price;
            run_request(OP_ADD, 1'b0, 3, 16'd50, price, next_id, 0);
            next_id++;
        end
        run_request(OP_ADD, 1'b0, 3, 16'd50, 32'd100, next_id, 0);
        next_id++;
        check_value("o_best_ask", last_ask, lowest);
        check_value("o_best_bid", last_bid, '0);
    endtask

    task automatic ready_backpressure();
        int hold;
        hold = 1 + ($urandom % 20);
        run_request(OP_ADD, 1'b1, 2, 16'd40, 32'(1000 + ($urandom % 500)), next_id, hold);
        next_id++;
        run_request(OP_ADD, 1'b0, 2, 16'd40, 32'(2000 + ($urandom % 500)), next_id, 0);
        next_id++;
    endtask

    initial begin
        void'($urandom(32'hdbef));
        i_reset_n             = 1'b0;
        i_data_valid          = 1'b0;
        i_trade_type          = 1'b0;
        i_stock_id            = '0;
        i_order_type          = '0;
        i_quantity            = '0;
        i_price               = '0;
        i_order_id            = '0;
        i_trading_logic_ready = 1'b0;
        next_id               = 1;
        last_bid              = '0;
        last_ask              = '0;
        for (int k = 0; k < `OB_NUM_STOCKS; k++) begin
            ref_count[k][0] = 0;
            ref_count[k][1] = 0;
        end
        repeat (5) @(posedge i_clk);
        i_reset_n <= 1'b1;

        check_reset_state();
        random_adds();
        cancel_orders();
        execute_orders();
        fill_side();
        ready_backpressure();

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verification/order_book_sva.sv ====
/* order book port assertions: busy and valid exclusive, result hold under
   back-pressure, valid low after reset */

`timescale 1ns/1ns

`include "ob_defines.svh"

module order_book_sva (
    input logic                   i_clk,
    input logic                   i_reset_n,
    input logic                   i_ready,
    input logic [`OB_PRICE_W-1:0] i_best_bid,
    input logic [`OB_PRICE_W-1:0] i_best_ask,
    input logic                   i_matched,
    input logic                   i_out_valid,
    input logic                   i_busy
);

    busy_valid_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_busy && i_out_valid))
        else $error("o_book_busy and o_data_valid high in the same cycle");

    // result frozen while the trading logic holds ready low
    result_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_out_valid && !i_ready) |=> (i_out_valid && $stable(i_best_bid)
            && $stable(i_best_ask) && $stable(i_matched)))
        else $error("result changed while ready was low");

    valid_low_after_reset: assert property (@(posedge i_clk) !i_reset_n |=> !i_out_valid)
        else $error("o_data_valid high right after reset");

endmodule

// ==== verification/tb_clock.sv ====
/* testbench clock source, 10 ns period */

`timescale 1ns/1ns

module tb_clock (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #5 o_clk = ~o_clk;   // half period

endmodule

// ==== source/order_book_top.sv ====
/* limit order book top: capture, controller, storage, scan and output side */

`timescale 1ns/1ns

`include "ob_defines.svh"

module order_book_top import ob_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_data_valid,
    input  logic                   i_trade_type,
    input  logic [`OB_STOCK_W-1:0] i_stock_id,
    input  logic [1:0]             i_order_type,
    input  logic [`OB_QTY_W-1:0]   i_quantity,
    input  logic [`OB_PRICE_W-1:0] i_price,
    input  logic [`OB_ID_W-1:0]    i_order_id,
    input  logic                   i_trading_logic_ready,
    output logic [`OB_PRICE_W-1:0] o_best_bid,
    output logic [`OB_PRICE_W-1:0] o_best_ask,
    output logic                   o_matched,
    output logic                   o_data_valid,
    output logic                   o_book_busy
);

    order_req_t             req;
    logic                   req_valid;
    logic                   idle;
    storage_cmd_e           cmd;
    book_side_e             side;
    logic [`OB_STOCK_W-1:0] stock;
    logic [`OB_SLOT_W-1:0]  slot;
    book_entry_t            wr_entry;
    book_entry_t            rd_entry;
    logic [`OB_COUNT_W-1:0] count;
    logic                   scan_clear;
    logic                   scan_sample;
    quote_t                 scan_quote;
    quote_t                 final_quote;
    logic                   done;
    logic                   matched;
    logic                   book_release;

    order_capture u_capture (
        .i_clk, .i_reset_n, .i_data_valid, .i_trade_type, .i_stock_id,
        .i_order_type, .i_quantity, .i_price, .i_order_id,
        .i_idle(idle), .o_req(req), .o_req_valid(req_valid)
    );

    book_controller u_controller (
        .i_clk, .i_reset_n, .i_req(req), .i_req_valid(req_valid),
        .i_count(count), .i_entry(rd_entry), .i_quote(scan_quote), .i_release(book_release),
        .o_cmd(cmd), .o_side(side), .o_stock(stock), .o_slot(slot), .o_entry(wr_entry),
        .o_scan_clear(scan_clear), .o_scan_sample(scan_sample), .o_done(done),
        .o_matched(matched), .o_quote(final_quote), .o_idle(idle), .o_book_busy
    );

    book_storage u_storage (
        .i_clk, .i_reset_n, .i_cmd(cmd), .i_side(side), .i_stock(stock), .i_slot(slot),
        .i_entry(wr_entry), .o_entry(rd_entry), .o_count(count)
    );

    best_price_scan u_scan (
        .i_clk, .i_reset_n, .i_clear(scan_clear), .i_sample(scan_sample),
        .i_side(side), .i_entry(rd_entry), .o_quote(scan_quote)
    );

    quote_output u_output (
        .i_clk, .i_reset_n, .i_done(done), .i_matched(matched), .i_stock(stock),
        .i_quote(final_quote), .i_trading_logic_ready, .o_best_bid, .o_best_ask,
        .o_matched, .o_data_valid, .o_release(book_release)
    );

endmodule

// ==== source/quote_output.sv ====
/* output side: per-stock quote rows, result hold until the trading logic takes it */

`timescale 1ns/1ns

`include "ob_defines.svh"

module quote_output import ob_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_done,
    input  logic                   i_matched,
    input  logic [`OB_STOCK_W-1:0] i_stock,
    input  quote_t                 i_quote,
    input  logic                   i_trading_logic_ready,
    output logic [`OB_PRICE_W-1:0] o_best_bid,
    output logic [`OB_PRICE_W-1:0] o_best_ask,
    output logic                   o_matched,
    output logic                   o_data_valid,
    output logic                   o_release
);

    quote_t                 quote_rows [`OB_NUM_STOCKS];
    logic [`OB_STOCK_W-1:0] shown_stock;   // stock of the last finished request

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int k = 0; k < `OB_NUM_STOCKS; k++) begin
                quote_rows[k] <= '0;
            end
            shown_stock  <= '0;
            o_matched    <= 1'b0;
            o_data_valid <= 1'b0;
        end else if (i_done) begin
            quote_rows[i_stock] <= i_quote;
            shown_stock         <= i_stock;
            o_matched           <= i_matched;
            o_data_valid        <= 1'b1;
        end else if (o_release) begin
            o_data_valid <= 1'b0;
        end
    end

    // taken on the edge where ready is seen with valid
    assign o_release  = o_data_valid && i_trading_logic_ready;
    assign o_best_bid = quote_rows[shown_stock].bid;
    assign o_best_ask = quote_rows[shown_stock].ask;

endmodule

// ==== source/book_controller.sv ====
/* order book FSM: append or search and remove, then rescan
   bid and ask of the stock and hand the quote to the output side */

`timescale 1ns/1ns

`include "ob_defines.svh"

module book_controller import ob_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  order_req_t             i_req,
    input  logic                   i_req_valid,
    input  logic [`OB_COUNT_W-1:0] i_count,
    input  book_entry_t            i_entry,
    input  quote_t                 i_quote,
    input  logic                   i_release,
    output storage_cmd_e           o_cmd,
    output book_side_e             o_side,
    output logic [`OB_STOCK_W-1:0] o_stock,
    output logic [`OB_SLOT_W-1:0]  o_slot,
    output book_entry_t            o_entry,
    output logic                   o_scan_clear,
    output logic                   o_scan_sample,
    output logic                   o_done,
    output logic                   o_matched,
    output quote_t                 o_quote,
    output logic                   o_idle,
    output logic                   o_book_busy
);

    typedef enum logic [2:0] {
        S_IDLE, S_ADD, S_SEARCH, S_SHIFT, S_SCAN, S_DONE, S_WAIT
    } state_e;

    state_e                 state;
    book_side_e             cur_side;
    logic [`OB_SLOT_W-1:0]  slot;
    logic                   matched;
    logic [`OB_COUNT_W-1:0] slot_ext;
    logic                   in_range;
    logic                   has_next;   // another occupied slot above this one
    logic                   hit;
    logic                   remove;

    assign slot_ext = {1'b0, slot};
    assign in_range = (slot_ext < i_count);
    assign has_next = ((slot_ext + 1'b1) < i_count);
    assign hit      = in_range && (i_entry.id == i_req.id);
    assign remove   = (i_req.op == OP_CANCEL) || (i_req.qty >= i_entry.qty);

    always_comb begin
        o_cmd = ST_NONE;
        o_entry = '{qty: i_req.qty, price: i_req.price, id: i_req.id};
        case (state)
            S_ADD: begin
                if (i_count < `OB_BOOK_DEPTH) o_cmd = ST_APPEND;
            end
            S_SEARCH: begin
                if (hit && !remove) begin   // partial execute
                    o_cmd = ST_SET_QTY;
                    o_entry.qty = i_entry.qty - i_req.qty;
                end
            end
            S_SHIFT: begin
                if (has_next) o_cmd = ST_SHIFT_DOWN;
                else o_cmd = ST_DROP_LAST;
            end
            default: ;
        endcase
    end

    assign o_side        = (state == S_ADD) ? i_req.side : cur_side;
    assign o_stock       = i_req.stock;
    assign o_slot        = slot;
    assign o_scan_clear  = (state == S_SCAN) && (cur_side == SIDE_BID) && (slot == '0);
    assign o_scan_sample = (state == S_SCAN) && in_range;
    assign o_done        = (state == S_DONE);
    assign o_matched     = matched;
    assign o_quote       = i_quote;
    assign o_idle        = (state == S_IDLE) && !i_req_valid;
    assign o_book_busy   = i_req_valid || ((state != S_IDLE) && (state != S_WAIT));

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state    <= S_IDLE;
            cur_side <= SIDE_BID;
            slot     <= '0;
            matched  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_req_valid) begin
                        matched  <= 1'b0;
                        cur_side <= SIDE_BID;   // search and scan both start on bids
                        slot     <= '0;
                        state    <= (i_req.op == OP_ADD) ? S_ADD : S_SEARCH;
                    end
                end
                S_ADD: begin
                    matched <= (i_count < `OB_BOOK_DEPTH);
                    state   <= S_SCAN;
                end
                S_SEARCH: begin
                    if (hit) begin
                        matched <= 1'b1;
                        if (remove) begin
                            state <= S_SHIFT;   // slot and side stay on the hit
                        end else begin
                            cur_side <= SIDE_BID;
                            slot     <= '0;
                            state    <= S_SCAN;
                        end
                    end else if (has_next) begin
                        slot <= slot + 1'b1;
                    end else if (cur_side == SIDE_BID) begin
                        cur_side <= SIDE_ASK;
                        slot     <= '0;
                    end else begin
                        cur_side <= SIDE_BID;   // id not found
                        slot     <= '0;
                        state    <= S_SCAN;
                    end
                end
                S_SHIFT: begin
                    if (has_next) begin
                        slot <= slot + 1'b1;
                    end else begin
                        cur_side <= SIDE_BID;
                        slot     <= '0;
                        state    <= S_SCAN;
                    end
                end
                S_SCAN: begin
                    if (has_next) begin
                        slot <= slot + 1'b1;
                    end else if (cur_side == SIDE_BID) begin
                        cur_side <= SIDE_ASK;
                        slot     <= '0;
                    end else begin
                        state <= S_DONE;   // quote settles on this edge
                    end
                end
                S_DONE: state <= S_WAIT;
                S_WAIT: begin
                    if (i_release) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== source/best_price_scan.sv ====
/* best price accumulator: highest bid and lowest ask over the sampled entries */

`timescale 1ns/1ns

`include "ob_defines.svh"

module best_price_scan import ob_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic        i_clear,    // may arrive with the first sample
    input  logic        i_sample,
    input  book_side_e  i_side,
    input  book_entry_t i_entry,
    output quote_t      o_quote
);

    logic [`OB_PRICE_W-1:0] best_bid;
    logic [`OB_PRICE_W-1:0] best_ask;
    logic                   bid_seen;
    logic                   ask_seen;
    logic                   bid_live;
    logic                   ask_live;
    logic                   take_bid;
    logic                   take_ask;

    // seen flags as they stand for this sample
    assign bid_live = bid_seen && !i_clear;
    assign ask_live = ask_seen && !i_clear;

    assign take_bid = i_sample && (i_side == SIDE_BID)
                      && (!bid_live || (i_entry.price > best_bid));
    assign take_ask = i_sample && (i_side == SIDE_ASK)
                      && (!ask_live || (i_entry.price < best_ask));

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            bid_seen <= 1'b0;
            ask_seen <= 1'b0;
        end else begin
            bid_seen <= bid_live || take_bid;
            ask_seen <= ask_live || take_ask;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_bid) best_bid <= i_entry.price;
        if (take_ask) best_ask <= i_entry.price;
    end

    // an empty side quotes 0
    assign o_quote.bid = bid_seen ? best_bid : '0;
    assign o_quote.ask = ask_seen ? best_ask : '0;

endmodule

// ==== source/book_storage.sv ====
/* resting order storage per stock and side, packed into the low slots,
   with append, quantity rewrite, shift-down and drop of the top slot */

`timescale 1ns/1ns

`include "ob_defines.svh"

module book_storage import ob_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  storage_cmd_e           i_cmd,
    input  book_side_e             i_side,
    input  logic [`OB_STOCK_W-1:0] i_stock,
    input  logic [`OB_SLOT_W-1:0]  i_slot,
    input  book_entry_t            i_entry,
    output book_entry_t            o_entry,
    output logic [`OB_COUNT_W-1:0] o_count
);

    book_entry_t            slots  [2][`OB_NUM_STOCKS][`OB_BOOK_DEPTH];
    logic [`OB_COUNT_W-1:0] counts [2][`OB_NUM_STOCKS];

    logic [`OB_COUNT_W-1:0] cur_count;
    logic [`OB_SLOT_W-1:0]  top_slot;
    logic [`OB_SLOT_W-1:0]  next_slot;
    logic                   has_room;
    logic                   not_empty;

    assign cur_count = counts[i_side][i_stock];
    assign top_slot  = cur_count[`OB_SLOT_W-1:0] - 1'b1;
    assign next_slot = i_slot + 1'b1;
    assign has_room  = (cur_count < `OB_BOOK_DEPTH);
    assign not_empty = (cur_count != '0);

    // zero-cycle read of the addressed slot and its side count
    assign o_entry = slots[i_side][i_stock][i_slot];
    assign o_count = cur_count;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < `OB_NUM_STOCKS; k++) begin
                    counts[s][k] <= '0;
                end
            end
        end else begin
            case (i_cmd)
                ST_APPEND: begin
                    if (has_room) counts[i_side][i_stock] <= cur_count + 1'b1;
                end
                ST_DROP_LAST: begin
                    if (not_empty) counts[i_side][i_stock] <= cur_count - 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (i_cmd)
            ST_APPEND: begin
                // a full side ignores the add
                if (has_room) slots[i_side][i_stock][cur_count[`OB_SLOT_W-1:0]] <= i_entry;
            end
            ST_SET_QTY: begin
                slots[i_side][i_stock][i_slot].qty <= i_entry.qty;
            end
            ST_SHIFT_DOWN: begin
                slots[i_side][i_stock][i_slot] <= slots[i_side][i_stock][next_slot];
            end
            ST_DROP_LAST: begin
                if (not_empty) slots[i_side][i_stock][top_slot] <= '0;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/order_capture.sv ====
/* request capture: registers one legal request while the book is idle */

`timescale 1ns/1ns

`include "ob_defines.svh"

module order_capture import ob_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_data_valid,
    input  logic                   i_trade_type,   // 1 buy, 0 sell
    input  logic [`OB_STOCK_W-1:0] i_stock_id,
    input  logic [1:0]             i_order_type,
    input  logic [`OB_QTY_W-1:0]   i_quantity,
    input  logic [`OB_PRICE_W-1:0] i_price,
    input  logic [`OB_ID_W-1:0]    i_order_id,
    input  logic                   i_idle,
    output order_req_t             o_req,
    output logic                   o_req_valid
);

    logic legal_op;
    logic accept;

    assign legal_op = (i_order_type != 2'd3);
    assign accept   = i_data_valid && i_idle && legal_op;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= accept;   // one cycle pulse per request
        end
    end

    // the fields stay put until the next accepted request
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_req.side  <= book_side_e'(i_trade_type);
            o_req.stock <= i_stock_id;
            o_req.op    <= order_op_e'(i_order_type);
            o_req.qty   <= i_quantity;
            o_req.price <= i_price;
            o_req.id    <= i_order_id;
        end
    end

endmodule

// ==== source/ob_pkg.sv ====
/* order book types: request codes, book entries, requests, quotes
   and the command set of the slot storage */

`include "ob_defines.svh"

package ob_pkg;

    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2   // code 3 never gets past capture
    } order_op_e;

    typedef enum logic {
        SIDE_ASK = 1'b0,
        SIDE_BID = 1'b1
    } book_side_e;

    typedef struct packed {
        logic [`OB_QTY_W-1:0]   qty;
        logic [`OB_PRICE_W-1:0] price;
        logic [`OB_ID_W-1:0]    id;
    } book_entry_t;

    typedef struct packed {
        book_side_e             side;
        logic [`OB_STOCK_W-1:0] stock;
        order_op_e              op;
        logic [`OB_QTY_W-1:0]   qty;    // add size or executed size
        logic [`OB_PRICE_W-1:0] price;
        logic [`OB_ID_W-1:0]    id;
    } order_req_t;

    typedef struct packed {
        logic [`OB_PRICE_W-1:0] bid;
        logic [`OB_PRICE_W-1:0] ask;
    } quote_t;

    typedef enum logic [2:0] {
        ST_NONE,
        ST_APPEND,
        ST_SET_QTY,
        ST_SHIFT_DOWN,
        ST_DROP_LAST
    } storage_cmd_e;

endpackage

// ==== source/ob_defines.svh ====
/* order book sizes and field widths, shared by the package, RTL and testbench */

`ifndef OB_DEFINES_SVH
`define OB_DEFINES_SVH

// book geometry
`define OB_NUM_STOCKS  4
`define OB_BOOK_DEPTH  8   // resting orders per side of one stock

// index widths, must cover the geometry above
`define OB_STOCK_W     2
`define OB_SLOT_W      3
`define OB_COUNT_W     4   // one bit wider than a slot index so a full side fits

// order fields
`define OB_PRICE_W     32
`define OB_QTY_W       16
`define OB_ID_W        32

`endif
